// File: itlb_sys.f
itlb_addr_pkg.sv
itlb_walk_pkg.sv
itlb_entry_array.sv
itlb_miss_ctrl.sv
itlb_walk_port.sv
itlb_top.sv
tb_page_walker.sv
tb_itlb_top.sv

// File: Bender.yml
package:
  name: itlb_sys

sources:
  - itlb_addr_pkg.sv
  - itlb_walk_pkg.sv
  - itlb_entry_array.sv
  - itlb_miss_ctrl.sv
  - itlb_walk_port.sv
  - itlb_top.sv
  - target: test
    files:
      - tb_page_walker.sv
      - tb_itlb_top.sv

// File: tb_itlb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_itlb_top;
    localparam int TIMEOUT = 200;
    localparam int MAX_ROWS = 32;

    // Pages used by the table.
    localparam itlb_addr_pkg::vaddr_t VA_A  = 32'h0123_4abc;
    localparam itlb_addr_pkg::vaddr_t VA_B  = 32'h0234_5678;
    localparam itlb_addr_pkg::vaddr_t VA_C  = 32'h0077_7010;
    localparam itlb_addr_pkg::vaddr_t VA_S  = 32'h8112_2344;   // Superpage.
    localparam itlb_addr_pkg::vaddr_t VA_S2 = 32'h811f_f004;   // Same superpage.
    localparam itlb_addr_pkg::vaddr_t VA_N  = 32'h40ab_c120;   // Execute clear.
    localparam itlb_addr_pkg::vaddr_t VA_F  = 32'h3012_3ff0;   // Walk fault.
    localparam itlb_addr_pkg::vaddr_t VA_E  = 32'h0888_8444;   // Error on first walk.
    localparam itlb_addr_pkg::vaddr_t VA_G  = 32'h0505_0a0c;

    typedef struct packed {
        logic [1:0]             req;
        itlb_addr_pkg::vaddr_t  va0;
        itlb_addr_pkg::vaddr_t  va1;
        logic                   te;
        logic                   fl;
        logic [3:0]             hold;
        logic [1:0]             walks;   // 3 leaves the count open.
        itlb_addr_pkg::vaddr_t  wa0;
        itlb_addr_pkg::vaddr_t  wa1;
        itlb_addr_pkg::paddr_t  pa0;
        itlb_addr_pkg::paddr_t  pa1;
        logic [1:0]             fault;
    } row_t;

    logic                   clk;
    logic                   rst;
    logic [1:0]             fetch_req;
    itlb_addr_pkg::vaddr_t  fetch_vaddr0;
    itlb_addr_pkg::vaddr_t  fetch_vaddr1;
    logic                   fetch_ready;
    logic                   fetch_flush;
    logic                   trans_en;
    logic                   fetch_miss;
    itlb_addr_pkg::paddr_t  fetch_paddr0;
    itlb_addr_pkg::paddr_t  fetch_paddr1;
    logic [1:0]             fetch_fault;
    logic                   walk_req;
    itlb_addr_pkg::vaddr_t  walk_vaddr;
    logic                   walk_ready;
    logic                   walk_valid;
    itlb_addr_pkg::ppn_t    walk_ppn;
    logic                   walk_super;
    logic                   walk_x;
    logic                   walk_fault;
    logic                   walk_error;

    row_t                   rows     [MAX_ROWS];
    string                  row_name [MAX_ROWS];
    int                     nrows;
    int                     errors;
    int                     rows_run;
    logic                   timed_out;
    itlb_addr_pkg::vaddr_t  walk_log [$];

    itlb_top #(.ENTRIES(8)) dut0 (
        .clk, .rst, .fetch_req, .fetch_vaddr0, .fetch_vaddr1, .fetch_ready,
        .fetch_flush, .trans_en, .fetch_miss, .fetch_paddr0, .fetch_paddr1,
        .fetch_fault, .walk_req, .walk_vaddr, .walk_ready, .walk_valid,
        .walk_ppn, .walk_super, .walk_x, .walk_fault, .walk_error
    );

    tb_page_walker walker (
        .clk, .rst, .walk_req, .walk_vaddr, .walk_ready, .walk_valid,
        .walk_ppn, .walk_super, .walk_x, .walk_fault, .walk_error
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Walker transfers, taken half a cycle before the edge that performs them.
    always @(negedge clk) begin
        if (!rst && walk_req && walk_ready && !fetch_flush)
            walk_log.push_back(walk_vaddr);
    end

    // ########################################################################
    // Expected translation from the page-table rule.
    function automatic itlb_addr_pkg::paddr_t translate(input itlb_addr_pkg::vaddr_t va);
        itlb_addr_pkg::vpn_t vpn;
        itlb_addr_pkg::ppn_t ppn;
        vpn = va[31:12];
        ppn = {2'b00, vpn} ^ 22'h15a5a;
        if (vpn[19])
            ppn[9:0] = vpn[9:0];                 // Superpage keeps level 0.
        return {ppn, va[11:0]};
    endfunction

    function automatic logic fetch_denied(input itlb_addr_pkg::vaddr_t va);
        itlb_addr_pkg::vpn_t vpn;
        vpn = va[31:12];
        return vpn[18] || (vpn[17] && vpn[16]);
    endfunction

    task automatic add_row(input string name, input logic [1:0] req,
                           input itlb_addr_pkg::vaddr_t va0, input itlb_addr_pkg::vaddr_t va1,
                           input logic te, input logic fl, input int hold, input int walks,
                           input itlb_addr_pkg::vaddr_t wa0, input itlb_addr_pkg::vaddr_t wa1);
        row_t r;
        r.req   = req;
        r.va0   = va0;
        r.va1   = va1;
        r.te    = te;
        r.fl    = fl;
        r.hold  = hold[3:0];
        r.walks = walks[1:0];
        r.wa0   = wa0;
        r.wa1   = wa1;
        r.pa0   = te ? translate(va0) : {2'b00, va0};
        r.pa1   = te ? translate(va1) : {2'b00, va1};
        r.fault = {te && req[1] && fetch_denied(va1), te && req[0] && fetch_denied(va0)};
        rows[nrows]     = r;
        row_name[nrows] = name;
        nrows++;
    endtask

    task automatic build_table();
        add_row("bypass",          2'b11, VA_A, VA_B,         0, 0, 0, 0, 0, 0);
        add_row("bypass high",     2'b11, VA_F, 32'hffff_fffc, 0, 0, 0, 0, 0, 0);
        add_row("miss and fill",   2'b01, VA_A, 32'h0,        1, 0, 0, 1, VA_A, 0);
        add_row("hit both",        2'b11, 32'h0123_4000, 32'h0123_4ffc, 1, 0, 0, 0, 0, 0);
        add_row("dual miss held",  2'b11, VA_B, VA_C,         1, 0, 4, 2, VA_B, VA_C);
        add_row("dual hit",        2'b11, VA_C, VA_B,         1, 0, 0, 0, 0, 0);
        add_row("superpage walk",  2'b01, VA_S, 32'h0,        1, 0, 0, 1, VA_S, 0);
        add_row("superpage hit",   2'b10, 32'h0, VA_S2,       1, 0, 0, 0, 0, 0);
        add_row("no execute walk", 2'b11, VA_A, VA_N,         1, 0, 0, 1, VA_N, 0);
        add_row("no execute hit",  2'b01, VA_N, 32'h0,        1, 0, 0, 0, 0, 0);
        add_row("walk fault",      2'b01, VA_F, 32'h0,        1, 0, 0, 1, VA_F, 0);
        add_row("fault not kept",  2'b01, VA_F, 32'h0,        1, 0, 0, 1, VA_F, 0);
        add_row("error retry",     2'b01, VA_E, 32'h0,        1, 0, 0, 2, VA_E, VA_E);
        add_row("flush",           2'b00, 32'h0, 32'h0,       1, 1, 0, 0, 0, 0);
        add_row("miss after flush", 2'b01, VA_A, 32'h0,       1, 0, 0, 1, VA_A, 0);
        add_row("dual after flush", 2'b11, VA_B, VA_S,        1, 0, 0, 2, VA_B, VA_S);
        add_row("flush in walk",   2'b01, VA_G, 32'h0,        1, 1, 0, 3, VA_G, 0);
        add_row("hit after abort", 2'b01, VA_G, 32'h0,        1, 0, 0, 0, 0, 0);
        add_row("dual miss held 2", 2'b11, VA_E, VA_A,        1, 0, 3, 2, VA_E, VA_A);
    endtask

    // ########################################################################
    // Row execution.
    task automatic check_outputs(input row_t r, input int n);
        if (fetch_miss) begin
            $display("mismatch fetch_miss: got %h, expected %h (row %0d)",
                     fetch_miss, 1'b0, n);
            errors++;
        end
        if (r.req[0] && fetch_paddr0 !== r.pa0) begin
            $display("mismatch fetch_paddr0: got %h, expected %h (row %0d)",
                     fetch_paddr0, r.pa0, n);
            errors++;
        end
        if (r.req[1] && fetch_paddr1 !== r.pa1) begin
            $display("mismatch fetch_paddr1: got %h, expected %h (row %0d)",
                     fetch_paddr1, r.pa1, n);
            errors++;
        end
        if (fetch_fault !== r.fault) begin
            $display("mismatch fetch_fault: got %h, expected %h (row %0d)",
                     fetch_fault, r.fault, n);
            errors++;
        end
    endtask

    task automatic wait_result(output int cyc);
        cyc = 0;
        @(negedge clk);
        while (fetch_miss && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (fetch_miss) begin
            $display("timeout: fetch_miss still high after %0d cycles", TIMEOUT);
            timed_out = 1'b1;
            errors++;
        end
    endtask

    // Flush one cycle after the walk request shows up.
    task automatic abort_walk();
        int cyc;
        cyc = 0;
        @(negedge clk);
        while (!walk_req && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (!walk_req) begin
            $display("timeout: no walk request within %0d cycles", TIMEOUT);
            timed_out = 1'b1;
            errors++;
            return;
        end
        @(posedge clk);
        #1;
        fetch_flush = 1'b1;
        @(posedge clk);
        #1;
        fetch_flush = 1'b0;
        @(negedge clk);
        if (!fetch_miss) begin
            $display("mismatch fetch_miss: got %h, expected %h after the flush",
                     fetch_miss, 1'b1);
            errors++;
        end
        if (walk_req) begin
            $display("mismatch walk_req: got %h, expected %h after the flush",
                     walk_req, 1'b0);
            errors++;
        end
    endtask

    task automatic run_row(input int n);
        row_t r;
        int   base;
        int   cyc;
        r            = rows[n];
        base         = walk_log.size();
        fetch_req    = r.req;
        fetch_vaddr0 = r.va0;
        fetch_vaddr1 = r.va1;
        trans_en     = r.te;
        fetch_ready  = (r.hold == 4'd0);
        fetch_flush  = r.fl && r.req == 2'b00;
        if (r.fl && r.req != 2'b00) begin
            abort_walk();
            if (timed_out)
                return;
        end
        wait_result(cyc);
        if (timed_out)
            return;
        if (r.walks == 2'd0 && cyc != 0) begin
            $display("row %0d: result came %0d cycles late, expected a hit", n, cyc);
            errors++;
        end
        if (r.walks != 2'd3 && walk_log.size() - base != int'(r.walks)) begin
            $display("mismatch walk count: got %h, expected %h (row %0d)",
                     walk_log.size() - base, r.walks, n);
            errors++;
        end else if (r.walks == 2'd3 && walk_log[walk_log.size() - 1] !== r.wa0) begin
            $display("mismatch walk_vaddr: got %h, expected %h (row %0d)",
                     walk_log[walk_log.size() - 1], r.wa0, n);
            errors++;
        end else begin
            if (r.walks != 2'd0 && r.walks != 2'd3 && walk_log[base] !== r.wa0) begin
                $display("mismatch walk_vaddr: got %h, expected %h (row %0d)",
                         walk_log[base], r.wa0, n);
                errors++;
            end
            if (r.walks == 2'd2 && walk_log[base + 1] !== r.wa1) begin
                $display("mismatch walk_vaddr: got %h, expected %h (row %0d)",
                         walk_log[base + 1], r.wa1, n);
                errors++;
            end
        end
        check_outputs(r, n);
        for (int h = 0; h < r.hold; h++) begin
            @(negedge clk);
            check_outputs(r, n);
        end
        @(posedge clk);
        #1;
        fetch_req   = 2'b00;                     // Idle cycle releases the hold.
        fetch_ready = 1'b1;
        fetch_flush = 1'b0;
        @(posedge clk);
        #1;
    endtask

    // ########################################################################
    initial begin
        int err0;
        rst          = 1'b1;
        fetch_req    = 2'b00;
        fetch_vaddr0 = '0;
        fetch_vaddr1 = '0;
        fetch_ready  = 1'b1;
        fetch_flush  = 1'b0;
        trans_en     = 1'b1;
        nrows        = 0;
        errors       = 0;
        rows_run     = 0;
        timed_out    = 1'b0;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        if (walk_req) begin
            $display("mismatch walk_req: got %h, expected %h after reset", walk_req, 1'b0);
            errors++;
        end
        if (fetch_miss) begin
            $display("mismatch fetch_miss: got %h, expected %h after reset",
                     fetch_miss, 1'b0);
            errors++;
        end
        @(posedge clk);
        #1;
        for (int i = 0; i < nrows; i++) begin
            err0 = errors;
            run_row(i);
            rows_run++;
            if (errors == err0)
                $display("row %0d %s: ok", i, row_name[i]);
            else
                $display("row %0d %s: FAILED", i, row_name[i]);
            if (timed_out)
                break;
        end
        $display("rows run %0d of %0d, errors %0d", rows_run, nrows, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_page_walker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_page_walker (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  walk_req,
    input  itlb_addr_pkg::vaddr_t      walk_vaddr,
    output logic                       walk_ready,
    output logic                       walk_valid,
    output itlb_addr_pkg::ppn_t        walk_ppn,
    output logic                       walk_super,
    output logic                       walk_x,
    output logic                       walk_fault,
    output logic                       walk_error
);
    logic [31:0]                rng;
    logic                       busy;
    int                         wait_cnt;
    itlb_addr_pkg::vpn_t        cur_vpn;
    itlb_addr_pkg::vpn_t        err_seen [$];

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic seen_before(input itlb_addr_pkg::vpn_t vpn);
        foreach (err_seen[i]) begin
            if (err_seen[i] == vpn)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    // Next ready or reply delay, 0 to 5 cycles.
    task automatic next_delay();
        rng      = xorshift(rng);
        wait_cnt = int'(rng % 32'd6);
    endtask

    // ########################################################################
    // PTE derived from the VPN.
    task automatic answer(input itlb_addr_pkg::vpn_t vpn);
        walk_valid = 1'b1;
        walk_ppn   = {2'b00, vpn} ^ 22'h15a5a;
        walk_super = vpn[19];
        walk_x     = !vpn[18];
        walk_fault = vpn[17] && vpn[16];
        walk_error = 1'b0;
        if (vpn[15] && !seen_before(vpn)) begin
            walk_error = 1'b1;              // First try of this page fails.
            err_seen.push_back(vpn);
        end
    endtask

    initial begin
        rng        = 32'hac47_96ee;
        busy       = 1'b0;
        cur_vpn    = '0;
        walk_ready = 1'b0;
        walk_valid = 1'b0;
        walk_ppn   = '0;
        walk_super = 1'b0;
        walk_x     = 1'b0;
        walk_fault = 1'b0;
        walk_error = 1'b0;
        next_delay();
        forever begin
            @(posedge clk);
            #1;
            walk_ready = 1'b0;
            walk_valid = 1'b0;
            walk_error = 1'b0;
            if (rst) begin
                busy = 1'b0;
            end else if (busy) begin
                if (wait_cnt == 0) begin
                    answer(cur_vpn);
                    busy = 1'b0;
                    next_delay();
                end else begin
                    wait_cnt--;
                end
            end else if (walk_req) begin
                if (wait_cnt == 0) begin
                    walk_ready = 1'b1;      // Transfer at the coming edge.
                    cur_vpn    = walk_vaddr[31:itlb_addr_pkg::PAGE_OFFSET];
                    busy       = 1'b1;
                    next_delay();
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: itlb_top.sv
`timescale 1ns/1ps
`default_nettype none

module itlb_top #(
    parameter int ENTRIES = 8
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic [1:0]            fetch_req,
    input  itlb_addr_pkg::vaddr_t      fetch_vaddr0,
    input  itlb_addr_pkg::vaddr_t      fetch_vaddr1,
    input  wire logic                  fetch_ready,
    input  wire logic                  fetch_flush,
    input  wire logic                  trans_en,
    output logic                       fetch_miss,
    output itlb_addr_pkg::paddr_t      fetch_paddr0,
    output itlb_addr_pkg::paddr_t      fetch_paddr1,
    output logic [1:0]                 fetch_fault,
    output logic                       walk_req,
    output itlb_addr_pkg::vaddr_t      walk_vaddr,
    input  wire logic                  walk_ready,
    input  wire logic                  walk_valid,
    input  itlb_addr_pkg::ppn_t        walk_ppn,
    input  wire logic                  walk_super,
    input  wire logic                  walk_x,
    input  wire logic                  walk_fault,
    input  wire logic                  walk_error
);
    logic [1:0]             lk_hit;
    logic [1:0]             lk_fault;
    itlb_addr_pkg::paddr_t  lk_paddr0;
    itlb_addr_pkg::paddr_t  lk_paddr1;
    logic                   wp_start;
    itlb_addr_pkg::vaddr_t  wp_addr;
    logic                   wp_done;
    logic                   wp_err;
    logic                   wp_fault;
    itlb_addr_pkg::paddr_t  wp_paddr;
    logic                   rf_en;
    itlb_addr_pkg::vpn_t    rf_vpn;
    itlb_addr_pkg::ppn_t    rf_ppn;
    logic                   rf_super;
    logic                   rf_x;

    itlb_entry_array #(.ENTRIES(ENTRIES)) u_array (
        .clk, .rst, .flush(fetch_flush), .trans_en, .req(fetch_req),
        .vaddr0(fetch_vaddr0), .vaddr1(fetch_vaddr1),
        .refill(rf_en), .refill_vpn(rf_vpn), .refill_ppn(rf_ppn),
        .refill_super(rf_super), .refill_x(rf_x),
        .hit(lk_hit), .paddr0(lk_paddr0), .paddr1(lk_paddr1), .fault(lk_fault)
    );

    itlb_miss_ctrl u_ctrl (
        .clk, .rst, .flush(fetch_flush), .req(fetch_req),
        .vaddr0(fetch_vaddr0), .vaddr1(fetch_vaddr1), .fetch_ready,
        .hit(lk_hit), .lk_paddr0, .lk_paddr1, .lk_fault,
        .walk_done(wp_done), .walk_err(wp_err), .walk_fault(wp_fault),
        .walk_paddr(wp_paddr), .walk_start(wp_start), .walk_addr(wp_addr),
        .fetch_miss, .out_paddr0(fetch_paddr0), .out_paddr1(fetch_paddr1),
        .out_fault(fetch_fault)
    );

    itlb_walk_port u_walk (
        .clk, .rst, .flush(fetch_flush), .start(wp_start), .addr(wp_addr),
        .walk_ready, .walk_valid, .walk_ppn, .walk_super, .walk_x,
        .walk_fault, .walk_error, .walk_req, .walk_vaddr,
        .done(wp_done), .err(wp_err), .fault(wp_fault), .paddr(wp_paddr),
        .refill(rf_en), .refill_vpn(rf_vpn), .refill_ppn(rf_ppn),
        .refill_super(rf_super), .refill_x(rf_x)
    );

endmodule

`default_nettype wire

// File: itlb_walk_port.sv
`timescale 1ns/1ps
`default_nettype none

module itlb_walk_port (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  flush,
    input  wire logic                  start,
    input  itlb_addr_pkg::vaddr_t      addr,
    input  wire logic                  walk_ready,
    input  wire logic                  walk_valid,
    input  itlb_addr_pkg::ppn_t        walk_ppn,
    input  wire logic                  walk_super,
    input  wire logic                  walk_x,
    input  wire logic                  walk_fault,
    input  wire logic                  walk_error,
    output logic                       walk_req,
    output itlb_addr_pkg::vaddr_t      walk_vaddr,
    output logic                       done,
    output logic                       err,
    output logic                       fault,
    output itlb_addr_pkg::paddr_t      paddr,
    output logic                       refill,
    output itlb_addr_pkg::vpn_t        refill_vpn,
    output itlb_addr_pkg::ppn_t        refill_ppn,
    output logic                       refill_super,
    output logic                       refill_x
);
    localparam int ST = itlb_walk_pkg::WALK_STAT_W;

    logic                                  inflight;
    logic                                  take;
    logic [itlb_walk_pkg::WALK_INFO_W-1:0] info;
    itlb_addr_pkg::ppn_t                   ppn_m;

    assign info = {walk_ppn, walk_super, walk_x, walk_fault, walk_error};
    assign take = walk_valid && inflight && !flush; // Stale replies drop here.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            walk_req <= 1'b0;
            inflight <= 1'b0;
        end else if (flush) begin
            walk_req <= 1'b0;
            inflight <= 1'b0;
        end else if (start) begin
            walk_req <= 1'b1;
            inflight <= 1'b0;
        end else if (walk_req && walk_ready) begin
            walk_req <= 1'b0;
            inflight <= 1'b1;
        end else if (take) begin
            inflight <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            walk_vaddr <= addr;
    end

    // ########################################################################
    // Reply decode and superpage merge.
    always_comb begin
        ppn_m = info[itlb_walk_pkg::WALK_INFO_W-1 -: $bits(itlb_addr_pkg::ppn_t)];
        if (info[ST+1])
            ppn_m[itlb_addr_pkg::VPN_PART-1:0] =
                walk_vaddr[itlb_addr_pkg::PAGE_OFFSET +: itlb_addr_pkg::VPN_PART];
    end

    assign done  = take && !info[0];
    assign err   = take && info[0];
    assign fault = info[1] || !info[ST];                 // No execute is a fault too.
    assign paddr = {ppn_m, walk_vaddr[itlb_addr_pkg::PAGE_OFFSET-1:0]};

    assign refill       = take && info[ST-1:0] == '0;
    assign refill_vpn   = walk_vaddr[31:itlb_addr_pkg::PAGE_OFFSET];
    assign refill_ppn   = walk_ppn;
    assign refill_super = info[ST+1];
    assign refill_x     = info[ST];

endmodule

`default_nettype wire

// File: itlb_miss_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module itlb_miss_ctrl (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  flush,
    input  wire logic [1:0]            req,
    input  itlb_addr_pkg::vaddr_t      vaddr0,
    input  itlb_addr_pkg::vaddr_t      vaddr1,
    input  wire logic                  fetch_ready,
    input  wire logic [1:0]            hit,
    input  itlb_addr_pkg::paddr_t      lk_paddr0,
    input  itlb_addr_pkg::paddr_t      lk_paddr1,
    input  wire logic [1:0]            lk_fault,
    input  wire logic                  walk_done,
    input  wire logic                  walk_err,
    input  wire logic                  walk_fault,
    input  itlb_addr_pkg::paddr_t      walk_paddr,
    output logic                       walk_start,
    output itlb_addr_pkg::vaddr_t      walk_addr,
    output logic                       fetch_miss,
    output itlb_addr_pkg::paddr_t      out_paddr0,
    output itlb_addr_pkg::paddr_t      out_paddr1,
    output logic [1:0]                 out_fault
);
    itlb_walk_pkg::miss_state_t state;
    logic                       hold;
    logic [1:0]                 miss;
    logic                       idle_start;
    logic                       buf_miss1;
    logic [1:0]                 buf_fault;
    itlb_addr_pkg::vaddr_t      buf_vaddr0;
    itlb_addr_pkg::vaddr_t      buf_vaddr1;
    itlb_addr_pkg::paddr_t      buf_paddr0;
    itlb_addr_pkg::paddr_t      buf_paddr1;

    assign miss       = req & ~hit;
    assign idle_start = state == itlb_walk_pkg::MISS_IDLE && !hold && |(miss & ~lk_fault);

    // ########################################################################
    // Walk requests, port 0 first.
    always_comb begin
        walk_start = 1'b0;
        walk_addr  = buf_vaddr0;
        case (state)
            itlb_walk_pkg::MISS_IDLE: begin
                walk_start = idle_start;
                walk_addr  = miss[0] ? vaddr0 : vaddr1;
            end
            itlb_walk_pkg::MISS_WALK0: begin
                if (walk_err) begin
                    walk_start = 1'b1;                // Same page again.
                end else if (walk_done && buf_miss1) begin
                    walk_start = 1'b1;
                    walk_addr  = buf_vaddr1;
                end
            end
            itlb_walk_pkg::MISS_WALK1: begin
                walk_start = walk_err;
                walk_addr  = buf_vaddr1;
            end
            default: ;
        endcase
        if (flush)
            walk_start = 1'b0;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= itlb_walk_pkg::MISS_IDLE;
            hold      <= 1'b0;
            buf_miss1 <= 1'b0;
            buf_fault <= '0;
        end else if (flush) begin
            state <= itlb_walk_pkg::MISS_IDLE;
            hold  <= 1'b0;
        end else begin
            case (state)
                itlb_walk_pkg::MISS_IDLE: begin
                    if (hold) begin
                        if (fetch_ready)
                            hold <= 1'b0;
                    end else if (idle_start) begin
                        buf_miss1 <= miss[1];
                        buf_fault <= lk_fault;
                        state     <= miss[0] ? itlb_walk_pkg::MISS_WALK0
                                             : itlb_walk_pkg::MISS_WALK1;
                    end
                end
                itlb_walk_pkg::MISS_WALK0: begin
                    if (walk_done) begin
                        buf_fault[0] <= walk_fault;
                        if (buf_miss1) begin
                            state <= itlb_walk_pkg::MISS_WALK1;
                        end else begin
                            state <= itlb_walk_pkg::MISS_IDLE;
                            hold  <= 1'b1;
                        end
                    end
                end
                itlb_walk_pkg::MISS_WALK1: begin
                    if (walk_done) begin
                        buf_fault[1] <= walk_fault;
                        state        <= itlb_walk_pkg::MISS_IDLE;
                        hold         <= 1'b1;
                    end
                end
                default: state <= itlb_walk_pkg::MISS_IDLE;
            endcase
        end
    end

    // Request buffer, lookup results first and walk results on top.
    always_ff @(posedge clk) begin
        if (state == itlb_walk_pkg::MISS_IDLE && !hold) begin
            buf_vaddr0 <= vaddr0;
            buf_vaddr1 <= vaddr1;
            buf_paddr0 <= lk_paddr0;
            buf_paddr1 <= lk_paddr1;
        end
        if (state == itlb_walk_pkg::MISS_WALK0 && walk_done)
            buf_paddr0 <= walk_paddr;
        if (state == itlb_walk_pkg::MISS_WALK1 && walk_done)
            buf_paddr1 <= walk_paddr;
    end

    // ########################################################################
    // Fetch side.
    assign fetch_miss = !hold && (state != itlb_walk_pkg::MISS_IDLE || |miss);
    assign out_paddr0 = hold ? buf_paddr0 : lk_paddr0;
    assign out_paddr1 = hold ? buf_paddr1 : lk_paddr1;
    assign out_fault  = hold ? buf_fault : lk_fault;

endmodule

`default_nettype wire

// File: itlb_entry_array.sv
`timescale 1ns/1ps
`default_nettype none

module itlb_entry_array #(
    parameter int ENTRIES = 8
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  flush,
    input  wire logic                  trans_en,
    input  wire logic [1:0]            req,
    input  itlb_addr_pkg::vaddr_t      vaddr0,
    input  itlb_addr_pkg::vaddr_t      vaddr1,
    input  wire logic                  refill,
    input  itlb_addr_pkg::vpn_t        refill_vpn,
    input  itlb_addr_pkg::ppn_t        refill_ppn,
    input  wire logic                  refill_super,
    input  wire logic                  refill_x,
    output logic [1:0]                 hit,
    output itlb_addr_pkg::paddr_t      paddr0,
    output itlb_addr_pkg::paddr_t      paddr1,
    output logic [1:0]                 fault
);
    localparam int IDX_W = $clog2(ENTRIES);
    localparam int VP = itlb_addr_pkg::VPN_PART;

    logic [ENTRIES-1:0]         valid;
    itlb_addr_pkg::vpn_t        tag   [ENTRIES];
    itlb_addr_pkg::ppn_t        ppn   [ENTRIES];
    logic [ENTRIES-1:0]         sup;
    logic [ENTRIES-1:0]         xok;
    logic [7:0]                 lfsr;
    logic [IDX_W-1:0]           victim;
    itlb_addr_pkg::vaddr_t      va    [2];
    itlb_addr_pkg::paddr_t      pa    [2];

    assign va[0]  = vaddr0;
    assign va[1]  = vaddr1;
    assign paddr0 = pa[0];
    assign paddr1 = pa[1];

    // ########################################################################
    // Lookup, one copy per fetch port.
    for (genvar p = 0; p < 2; p++) begin : g_port
        itlb_addr_pkg::vpn_t vpn;
        itlb_addr_pkg::ppn_t ppn_hit;
        logic                match;
        logic                sup_hit;
        logic                x_hit;

        assign vpn = va[p][31:itlb_addr_pkg::PAGE_OFFSET];

        always_comb begin
            match   = 1'b0;
            ppn_hit = '0;
            sup_hit = 1'b0;
            x_hit   = 1'b0;
            for (int i = 0; i < ENTRIES; i++) begin
                if (valid[i] && tag[i][2*VP-1:VP] == vpn[2*VP-1:VP] &&
                    (sup[i] || tag[i][VP-1:0] == vpn[VP-1:0])) begin
                    match   = 1'b1;
                    ppn_hit = ppn[i];
                    sup_hit = sup[i];
                    x_hit   = xok[i];
                end
            end
            if (sup_hit)
                ppn_hit[VP-1:0] = vpn[VP-1:0]; // Superpage keeps level 0 of the VPN.
        end

        assign hit[p]   = !trans_en || match;
        assign fault[p] = trans_en && req[p] && match && !x_hit;
        assign pa[p]    = trans_en ?
                          {ppn_hit, va[p][itlb_addr_pkg::PAGE_OFFSET-1:0]} : {2'b00, va[p]};
    end

    // ########################################################################
    // Refill way: lowest invalid entry, else the LFSR.
    always_comb begin
        victim = lfsr[IDX_W-1:0];
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (!valid[i])
                victim = IDX_W'(i);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
            lfsr  <= 8'h01;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]}; // Maximal length.
            if (flush)
                valid <= '0;
            else if (refill)
                valid[victim] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill && !flush) begin
            tag[victim] <= refill_vpn;
            ppn[victim] <= refill_ppn;
            sup[victim] <= refill_super;
            xok[victim] <= refill_x;
        end
    end

endmodule

`default_nettype wire

// File: itlb_walk_pkg.sv
`default_nettype none

package itlb_walk_pkg;

    // Miss handling steps, one walk per port.
    typedef enum logic [1:0] {
        MISS_IDLE,
        MISS_WALK0,
        MISS_WALK1
    } miss_state_t;

    // Status bits of a walk reply: fault above error.
    localparam int WALK_STAT_W = 2;

    // Reply packed as {ppn, super, x, fault, error}.
    localparam int WALK_INFO_W = $bits(itlb_addr_pkg::ppn_t) + 2 + WALK_STAT_W;

endpackage

`default_nettype wire

// File: itlb_addr_pkg.sv
`default_nettype none

package itlb_addr_pkg;

    // Sv32 address widths.
    typedef logic [31:0] vaddr_t;
    typedef logic [33:0] paddr_t;
    typedef logic [19:0] vpn_t;
    typedef logic [21:0] ppn_t;

    // Page offset width, 4 KiB pages.
    localparam int PAGE_OFFSET = 12;

    // Width of one VPN level; level 1 sits above level 0.
    localparam int VPN_PART = 10;

endpackage

`default_nettype wire
